// File: Bender.yml
package:
  name: frame_detector

sources:
  # Design, package first
  - files:
      - design/frame_detect_pkg.sv
      - design/frame_header_parser.sv
      - design/frame_rule_matcher.sv
      - design/match_log_serializer.sv
      - design/frame_detector_top.sv

  # Testbench
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/frame_detector_tb.sv

// File: build.f
design/frame_detect_pkg.sv
design/frame_header_parser.sv
design/frame_rule_matcher.sv
design/match_log_serializer.sv
design/frame_detector_top.sv
testbench/tb_clock_gen.sv
testbench/frame_detector_tb.sv

// File: design/frame_detect_pkg.sv
// Shared types and constants for the Ethernet frame detector
// Holds the parsed-frame and match-event structs, the rule entry and the log format
// Imported by every stage of the pipeline and by the top level
`default_nettype none

package frame_detect_pkg;

	localparam int NUM_RULES        = 4;  // One match bit per rule
	localparam int MAX_EXT_BYTES    = 16; // Payload bytes kept per frame
	localparam int LOG_HEADER_BYTES = 12; // Fixed part of a log record
	localparam int MIN_HEADER_BYTES = 14; // Dst MAC, src MAC, EtherType

	localparam logic [31:0] LOG_MAGIC = 32'h0242_5AFF; // Record marker, low bytes first

	// One parsed frame, valid for a single cycle
	typedef struct packed {
		logic         valid;
		logic [47:0]  dst_mac;
		logic [47:0]  src_mac;
		logic [15:0]  ethertype;
		logic [4:0]   payload_len; // 0 to MAX_EXT_BYTES
		logic [127:0] payload;     // Byte 0 in bits 7:0
	} parsed_frame_t;

	// Rule table entry
	typedef struct packed {
		logic        enable;
		logic [15:0] ethertype;
	} match_rule_t;

	// New event is signalled by a change of event_id
	typedef struct packed {
		logic [NUM_RULES-1:0] match;
		logic [1:0]           event_id;
		logic [4:0]           ext_num;
		logic [127:0]         ext_data;
	} match_event_t;

	typedef enum logic [1:0] {
		HEADER,
		PAYLOAD,
		DISCARD
	} parse_state_e;

	typedef enum logic {
		IDLE,
		SEND
	} log_state_e;

endpackage

`default_nettype wire

// File: design/frame_detector_top.sv
// Top level of the Ethernet frame detector
// Chains parser, rule matcher and log serializer on a passive frame tap
// Stream width and direction id are set here and passed to the serializer
`timescale 1ns/10ps
`default_nettype none

module frame_detector_top
	import frame_detect_pkg::*;
#(
	parameter int         LOG_WIDTH    = 64,
	parameter logic [7:0] DIRECTION_ID = 8'h41
) (
	input  logic                        clk,
	input  logic                        rst_n,

	// Monitored frame bytes, no back-pressure
	input  logic [7:0]                  rx_data,
	input  logic                        rx_valid,
	input  logic                        rx_last,

	input  match_rule_t [NUM_RULES-1:0] rules,
	input  logic [15:0]                 log_id,

	// Log record stream
	output logic [LOG_WIDTH-1:0]        log_tdata,
	output logic                        log_tlast,
	output logic                        log_tvalid,
	input  logic                        log_tready,

	output logic [31:0]                 overflow_count
);

	parsed_frame_t frame;
	match_event_t  log_event;

	frame_header_parser u_parser (
		.clk      (clk),
		.rst_n    (rst_n),
		.rx_data  (rx_data),
		.rx_valid (rx_valid),
		.rx_last  (rx_last),
		.frame    (frame)
	);

	frame_rule_matcher u_matcher (
		.clk       (clk),
		.rst_n     (rst_n),
		.rules     (rules),
		.frame     (frame),
		.log_event (log_event)
	);

	match_log_serializer #(
		.LOG_WIDTH    (LOG_WIDTH),
		.DIRECTION_ID (DIRECTION_ID)
	) u_serializer (
		.clk            (clk),
		.rst_n          (rst_n),
		.log_id         (log_id),
		.log_event      (log_event),
		.overflow_count (overflow_count),
		.log_tdata      (log_tdata),
		.log_tlast      (log_tlast),
		.log_tvalid     (log_tvalid),
		.log_tready     (log_tready)
	);

endmodule

`default_nettype wire

// File: design/frame_header_parser.sv
// First pipeline stage: takes the monitored byte stream and splits each frame
// into MAC addresses, EtherType and the first payload bytes
// One parsed frame is presented for one cycle after the last byte of a frame
`timescale 1ns/10ps
`default_nettype none

module frame_header_parser
	import frame_detect_pkg::*;
(
	input  logic          clk,
	input  logic          rst_n,
	input  logic [7:0]    rx_data,
	input  logic          rx_valid,
	input  logic          rx_last,
	output parsed_frame_t frame
);

	parse_state_e state;
	logic [3:0]   byte_cnt;    // Index inside the header or the payload
	logic         frame_valid;

	logic [47:0]  dst_mac_q;
	logic [47:0]  src_mac_q;
	logic [15:0]  ethertype_q;
	logic [4:0]   payload_cnt;
	logic [127:0] payload_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= HEADER;
			byte_cnt    <= '0;
			frame_valid <= 1'b0;
		end else begin
			frame_valid <= 1'b0;
			if (rx_valid) begin
				if (rx_last) begin
					state    <= HEADER;
					byte_cnt <= '0;
					// Runt frames end while still in the header
					frame_valid <= (state != HEADER) ||
						(byte_cnt == 4'(MIN_HEADER_BYTES - 1));
				end else begin
					case (state)
						HEADER: begin
							if (byte_cnt == 4'(MIN_HEADER_BYTES - 1)) begin
								state    <= PAYLOAD;
								byte_cnt <= '0;
							end else begin
								byte_cnt <= byte_cnt + 4'd1;
							end
						end
						PAYLOAD: begin
							if (byte_cnt == 4'(MAX_EXT_BYTES - 1))
								state <= DISCARD; // Rest of frame is ignored
							byte_cnt <= byte_cnt + 4'd1;
						end
						default: ; // DISCARD waits for rx_last
					endcase
				end
			end
		end
	end

	// Field capture, bytes arrive MSB first for MACs and EtherType
	always_ff @(posedge clk) begin
		if (rx_valid) begin
			case (state)
				HEADER: begin
					if (byte_cnt < 4'd6)
						dst_mac_q <= {dst_mac_q[39:0], rx_data};
					else if (byte_cnt < 4'd12)
						src_mac_q <= {src_mac_q[39:0], rx_data};
					else
						ethertype_q <= {ethertype_q[7:0], rx_data};
					if (byte_cnt == 4'd0) begin
						payload_q   <= '0; // No stale bytes from the previous frame
						payload_cnt <= '0;
					end
				end
				PAYLOAD: begin
					payload_q[{byte_cnt, 3'b000} +: 8] <= rx_data;
					payload_cnt <= payload_cnt + 5'd1; // Stops at 16 by leaving PAYLOAD
				end
				default: ;
			endcase
		end
	end

	assign frame = '{
		valid:       frame_valid,
		dst_mac:     dst_mac_q,
		src_mac:     src_mac_q,
		ethertype:   ethertype_q,
		payload_len: payload_cnt,
		payload:     payload_q
	};

	// Each frame yields at most one pulse, and frames take at least one byte
	a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		frame.valid |=> !frame.valid);

endmodule

`default_nettype wire

// File: design/frame_rule_matcher.sv
// Second pipeline stage: checks the EtherType of each parsed frame against
// the rule table and raises a log event for any hit
// Events are signalled by advancing a 2-bit rolling id
`timescale 1ns/10ps
`default_nettype none

module frame_rule_matcher
	import frame_detect_pkg::*;
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  match_rule_t [NUM_RULES-1:0]   rules,
	input  parsed_frame_t                 frame,
	output match_event_t                  log_event
);

	logic [NUM_RULES-1:0] hit;

	logic [1:0]           event_id;
	logic [NUM_RULES-1:0] match_q;
	logic [4:0]           ext_num_q;
	logic [127:0]         ext_data_q;

	always_comb begin
		for (int i = 0; i < NUM_RULES; i++) begin
			hit[i] = rules[i].enable && (rules[i].ethertype == frame.ethertype);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			event_id <= 2'd0;
		end else if (frame.valid && |hit) begin
			event_id <= event_id + 2'd1; // Wraps, downstream only looks for a change
		end
	end

	always_ff @(posedge clk) begin
		if (frame.valid && |hit) begin
			match_q    <= hit;
			ext_num_q  <= frame.payload_len;
			ext_data_q <= frame.payload;
		end
	end

	assign log_event = '{
		match:    match_q,
		event_id: event_id,
		ext_num:  ext_num_q,
		ext_data: ext_data_q
	};

	// Payload count from the parser stays within the record capacity
	a_ext_num_range: assert property (@(posedge clk) disable iff (!rst_n)
		(log_event.event_id != $past(log_event.event_id)) |->
			(log_event.ext_num <= 5'(MAX_EXT_BYTES)));

endmodule

`default_nettype wire

// File: design/match_log_serializer.sv
// Last pipeline stage: turns each match event into a log record and sends it
// as stream words with valid/ready handshake, low bytes first
// Events arriving during a transfer are dropped and counted in overflow_count
`timescale 1ns/10ps
`default_nettype none

module match_log_serializer
	import frame_detect_pkg::*;
#(
	parameter int         LOG_WIDTH    = 64,
	parameter logic [7:0] DIRECTION_ID = 8'h41
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [15:0]          log_id,
	input  match_event_t         log_event,
	output logic [31:0]          overflow_count,
	output logic [LOG_WIDTH-1:0] log_tdata,
	output logic                 log_tlast,
	output logic                 log_tvalid,
	input  logic                 log_tready
);

	localparam int RECORD_BITS = 8 * (LOG_HEADER_BYTES + MAX_EXT_BYTES); // 224
	localparam int BUF_BITS    = (LOG_WIDTH > RECORD_BITS) ? LOG_WIDTH : RECORD_BITS;
	localparam int WORD_BYTES  = LOG_WIDTH / 8;
	localparam int CNT_W       = $clog2(LOG_HEADER_BYTES + MAX_EXT_BYTES + WORD_BYTES + 1);

	log_state_e           state;
	logic [1:0]           last_event_id;
	logic [CNT_W-1:0]     tx_cnt;   // Bytes presented so far, including the current word
	logic [CNT_W-1:0]     tx_limit; // Record length in bytes
	logic [BUF_BITS-1:0]  tx_buf;
	logic [RECORD_BITS-1:0] record;
	logic                 new_event;

	assign new_event = (log_event.event_id != last_event_id);

	// Record layout, byte 0 in the low bits
	assign record = {
		log_event.ext_data,
		11'd0, log_event.ext_num,
		4'd0, log_event.match,
		DIRECTION_ID,
		16'd4 + 16'(log_event.ext_num), // Length counts from byte 8
		log_id,
		LOG_MAGIC
	};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state          <= IDLE;
			last_event_id  <= 2'd0;
			tx_cnt         <= '0;
			tx_limit       <= '0;
			overflow_count <= 32'd0;
		end else begin
			last_event_id <= log_event.event_id;
			case (state)
				IDLE: begin
					if (new_event) begin
						state    <= SEND;
						tx_cnt   <= CNT_W'(WORD_BYTES);
						tx_limit <= CNT_W'(LOG_HEADER_BYTES) + CNT_W'(log_event.ext_num);
					end
				end
				SEND: begin
					if (new_event)
						overflow_count <= overflow_count + 32'd1; // Event is lost
					if (log_tready) begin
						if (log_tlast)
							state <= IDLE;
						else
							tx_cnt <= tx_cnt + CNT_W'(WORD_BYTES);
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Record buffer, shifted down one word per transfer
	always_ff @(posedge clk) begin
		if (state == IDLE && new_event)
			tx_buf <= BUF_BITS'(record);
		else if (state == SEND && log_tready)
			tx_buf <= tx_buf >> LOG_WIDTH;
	end

	assign log_tvalid = (state == SEND);
	assign log_tlast  = (state == SEND) && (tx_cnt >= tx_limit);
	assign log_tdata  = tx_buf[LOG_WIDTH-1:0];

	// Stream rule: a stalled word holds its data and end marker
	a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(log_tvalid && !log_tready) |=>
			(log_tvalid && $stable(log_tdata) && $stable(log_tlast)));

endmodule

`default_nettype wire

// File: testbench/frame_detector_tb.sv
// Testbench for the Ethernet frame detector
// Sends random frames on the tap, predicts each log record from the rule table
// and checks every transferred log byte and the end marker
`timescale 1ns/10ps
`default_nettype none

module frame_detector_tb
	import frame_detect_pkg::*;
();

	localparam int         LOG_WIDTH  = 64;
	localparam logic [7:0] DIR_ID     = 8'h41;
	localparam int         WORD_BYTES = LOG_WIDTH / 8;
	localparam int         RESET_CYC  = 16;

	// Upper bounds of bytes sent and log words expected, per test
	localparam int TOTAL_BYTES = 24 + 54 + (22 + 22 + 12) + 20 * 54 + 4 * 24 + (24 + 17 + 34 + 14);
	localparam int TOTAL_WORDS = 3 + 4 + 0 + 20 * 4 + 6 + (3 + 2 + 4 + 2);
	localparam int CYCLE_LIMIT = 4 * TOTAL_BYTES + 4 * TOTAL_WORDS + RESET_CYC;

	localparam logic [15:0] ET_POOL [4] = '{16'h0800, 16'h88B5, 16'h88B6, 16'h1234};

	typedef logic [7:0] byte_q_t [$];

	logic                        clk;
	logic                        rst_n;
	logic [7:0]                  rx_data;
	logic                        rx_valid;
	logic                        rx_last;
	match_rule_t [NUM_RULES-1:0] rules;
	logic [15:0]                 log_id;
	logic [LOG_WIDTH-1:0]        log_tdata;
	logic                        log_tlast;
	logic                        log_tvalid;
	logic                        log_tready;
	logic [31:0]                 overflow_count;

	logic [31:0] rng_state = 32'h74df_7407;
	int          ready_mode;  // 0 high, 1 random, 2 held low
	byte_q_t     frame_q;
	logic [7:0]  exp_bytes [$];
	int          exp_len [$];
	logic        in_record;
	int          cur_len;
	int          word_base;
	int          words_seen;
	int          err_cnt;
	int          pass_cnt;
	int          fail_cnt;
	int          cycle_cnt;

	tb_clock_gen #(.RESET_CYCLES(RESET_CYC)) u_clk (.clk(clk), .rst_n(rst_n));

	frame_detector_top #(
		.LOG_WIDTH    (LOG_WIDTH),
		.DIRECTION_ID (DIR_ID)
	) dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.rx_data        (rx_data),
		.rx_valid       (rx_valid),
		.rx_last        (rx_last),
		.rules          (rules),
		.log_id         (log_id),
		.log_tdata      (log_tdata),
		.log_tlast      (log_tlast),
		.log_tvalid     (log_tvalid),
		.log_tready     (log_tready),
		.overflow_count (overflow_count)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function logic [31:0] rand_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Expected log record for one frame, empty when nothing is logged
	function automatic byte_q_t expected_record(input byte_q_t fr,
			input match_rule_t [NUM_RULES-1:0] rt, input logic [15:0] id,
			input logic [7:0] dir);
		byte_q_t              rec;
		logic [15:0]          et;
		logic [NUM_RULES-1:0] m;
		int                   n;
		logic [15:0]          len;
		if (fr.size() < 14)
			return rec;
		et = {fr[12], fr[13]};
		for (int i = 0; i < NUM_RULES; i++)
			m[i] = rt[i].enable && (rt[i].ethertype == et);
		if (m == '0)
			return rec;
		n   = (fr.size() - 14 > 16) ? 16 : fr.size() - 14;
		len = 16'(4 + n);
		rec = '{8'hFF, 8'h5A, 8'h42, 8'h02, id[7:0], id[15:8], len[7:0], len[15:8]};
		rec.push_back(dir);
		rec.push_back({4'd0, m});
		rec.push_back(8'(n));
		rec.push_back(8'd0);
		for (int k = 0; k < n; k++)
			rec.push_back(fr[14 + k]);
		return rec;
	endfunction

	// One falling edge, with log_tready updated for the next cycle
	task automatic next_cycle();
		logic [31:0] r;
		@(negedge clk);
		r = rand_word();
		case (ready_mode)
			0: log_tready = 1'b1;
			1: log_tready = r[0];
			default: log_tready = 1'b0;
		endcase
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			next_cycle();
			rx_valid = 1'b0;
			rx_last  = 1'b0;
			rx_data  = 8'd0;
		end
	endtask

	// Random MACs and payload, EtherType in bytes 12 and 13
	task automatic make_frame(input int total, input logic [15:0] et);
		logic [31:0] r;
		frame_q.delete();
		for (int i = 0; i < total; i++) begin
			r = rand_word();
			if (i == 12)
				frame_q.push_back(et[15:8]);
			else if (i == 13)
				frame_q.push_back(et[7:0]);
			else
				frame_q.push_back(r[7:0]);
		end
	endtask

	task automatic send_frame(input bit expect_log);
		byte_q_t rec;
		rec = expected_record(frame_q, rules, log_id, DIR_ID);
		if (expect_log && rec.size() != 0) begin
			foreach (rec[i])
				exp_bytes.push_back(rec[i]);
			exp_len.push_back(rec.size());
		end
		for (int i = 0; i < frame_q.size(); i++) begin
			next_cycle();
			rx_valid = 1'b1;
			rx_data  = frame_q[i];
			rx_last  = (i == frame_q.size() - 1);
		end
	endtask

	// Waits until every expected record is out and the stream is quiet
	task automatic wait_drain();
		idle_cycles(1);
		while (exp_len.size() != 0 || in_record || log_tvalid)
			idle_cycles(1);
		idle_cycles(4);
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (err_cnt == errs_before) begin
			pass_cnt++;
			$display("PASS  %s", name);
		end else begin
			fail_cnt++;
			$display("FAIL  %s (%0d errors)", name, err_cnt - errs_before);
		end
	endtask

	task automatic check_words(input int got, input int expected);
		assert (got == expected) else begin
			$display("** Error at %0t: %0d log words, expected %0d", $time, got, expected);
			err_cnt++;
		end
	endtask

	// Compares each transferred word against the expected byte queue
	always @(posedge clk) begin : compare_words
		int         idx;
		logic [7:0] got_byte;
		logic [7:0] exp_byte;
		logic       exp_last;
		if (rst_n && log_tvalid && log_tready) begin
			words_seen++;
			if (!in_record) begin
				assert (exp_len.size() != 0) else begin
					$display("** Error at %0t: unexpected log word %h", $time, log_tdata);
					err_cnt++;
				end
				if (exp_len.size() != 0) begin
					cur_len   = exp_len.pop_front();
					word_base = 0;
					in_record = 1'b1;
				end
			end
			if (in_record) begin
				for (int b = 0; b < WORD_BYTES; b++) begin
					idx = word_base + b;
					if (idx < cur_len) begin
						got_byte = log_tdata[8*b +: 8];
						exp_byte = exp_bytes.pop_front();
						assert (got_byte == exp_byte) else begin
							$display("** Error at %0t: record byte %0d is %h, expected %h",
								$time, idx, got_byte, exp_byte);
							err_cnt++;
						end
					end
				end
				exp_last = (word_base + WORD_BYTES >= cur_len);
				assert (log_tlast == exp_last) else begin
					$display("** Error at %0t: log_tlast %b at byte %0d, expected %b",
						$time, log_tlast, word_base, exp_last);
					err_cnt++;
				end
				word_base += WORD_BYTES;
				if (log_tlast) begin
					while (word_base < cur_len) begin // Keep later records aligned
						void'(exp_bytes.pop_front());
						word_base++;
					end
					in_record = 1'b0;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Something failed");
			$finish;
		end
	end

	initial begin
		int          e0;
		int          w0;
		logic [31:0] ovf0;
		logic [31:0] r;
		rx_data    = 8'd0;
		rx_valid   = 1'b0;
		rx_last    = 1'b0;
		log_tready = 1'b1;
		log_id     = 16'hA5C3;
		ready_mode = 0;
		in_record  = 1'b0;
		words_seen = 0;
		err_cnt    = 0;
		pass_cnt   = 0;
		fail_cnt   = 0;
		cycle_cnt  = 0;
		rules[0]   = '{enable: 1'b1, ethertype: 16'h0800};
		rules[1]   = '{enable: 1'b1, ethertype: 16'h88B5};
		rules[2]   = '{enable: 1'b1, ethertype: 16'h88B5}; // Same type as rule 1
		rules[3]   = '{enable: 1'b0, ethertype: 16'h88B6};
		while (rst_n !== 1'b1)
			@(negedge clk);
		idle_cycles(2);

		e0 = err_cnt;
		w0 = words_seen;
		make_frame(24, 16'h0800);
		send_frame(1);
		wait_drain();
		check_words(words_seen - w0, 3);
		report_test("single rule hit, 10 payload bytes", e0);

		e0 = err_cnt;
		w0 = words_seen;
		make_frame(54, 16'h88B5);
		send_frame(1);
		wait_drain();
		check_words(words_seen - w0, 4);
		report_test("two rule hit, payload capped at 16", e0);

		e0 = err_cnt;
		make_frame(12, 16'h0800); // Parser still holds the hitting EtherType 88B5
		send_frame(1);
		make_frame(22, 16'h88B6);
		send_frame(1);
		make_frame(22, 16'h1234);
		send_frame(1);
		repeat (30) begin
			idle_cycles(1);
			assert (!log_tvalid && exp_len.size() == 0) else begin
				$display("** Error at %0t: log output on a frame without a hit", $time);
				err_cnt++;
			end
		end
		report_test("disabled rule, no rule and runt frame", e0);

		e0 = err_cnt;
		ready_mode = 1;
		repeat (20) begin
			r = rand_word();
			make_frame(14 + int'(r[7:0]) % 41, ET_POOL[r[9:8]]);
			send_frame(1);
			wait_drain();
		end
		report_test("random frames with random stalls", e0);

		e0 = err_cnt;
		w0 = words_seen;
		ready_mode = 2;
		ovf0 = overflow_count;
		make_frame(24, 16'h0800);
		send_frame(1);
		idle_cycles(2);
		make_frame(24, 16'h88B5);
		send_frame(0); // Lost while the first record is stalled
		idle_cycles(2);
		make_frame(24, 16'h0800);
		send_frame(0);
		idle_cycles(6);
		ready_mode = 0;
		wait_drain();
		assert (overflow_count - ovf0 == 32'd2) else begin
			$display("** Error at %0t: overflow_count rose by %0d, expected 2",
				$time, overflow_count - ovf0);
			err_cnt++;
		end
		make_frame(24, 16'h88B5);
		send_frame(1);
		wait_drain();
		check_words(words_seen - w0, 6);
		report_test("overflow while stalled", e0);

		e0 = err_cnt;
		w0 = words_seen;
		make_frame(24, 16'h0800);
		send_frame(1);
		make_frame(17, 16'h88B5);
		send_frame(1);
		make_frame(34, 16'h0800);
		send_frame(1);
		make_frame(14, 16'h88B5);
		send_frame(1);
		wait_drain();
		check_words(words_seen - w0, 11);
		report_test("back-to-back frames", e0);

		$display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
// Clock and reset source for the frame detector testbench
// 10 ns clock, reset held low for RESET_CYCLES rising edges
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk) rst_n = 1'b1; // Released away from the active edge
	end

endmodule

`default_nettype wire
